//--- logic/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

  // one machine word, used for pc, bus address and instruction
  typedef logic [31:0] xlen_t;

  // first fetch address out of reset
  localparam xlen_t PC_RESET = 32'h8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;

  // fence.i, matched on the whole word
  localparam xlen_t INST_FENCE_I = 32'h0000_100f;

  // instruction handed to decode
  typedef struct packed {
    xlen_t pc;
    xlen_t inst;
    // fetched on a predicted path
    logic  spec;
  } fetch_rsp_t;

  // backend resolution, change and retire are single-cycle pulses
  typedef struct packed {
    logic  change;
    logic  retire;
    xlen_t npc;
    xlen_t pc;
  } resolve_t;

  // read bus request, held until the response arrives
  typedef struct packed {
    xlen_t addr;
    logic  valid;
  } mem_req_t;

  // read bus response
  typedef struct packed {
    xlen_t data;
    logic  valid;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- logic/l1i_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1i_cache
  import ifu_pkg::*;
#(
  parameter int IDX_W = 2,
  parameter int OFF_W = 1
) (
  input  wire logic     clk,
  input  wire logic     rst,
  // lookup side
  input  wire xlen_t    fetch_pc_i,
  input  wire logic     flush_all_i,
  output logic          hit_o,
  output xlen_t         inst_o,
  output logic          busy_o,
  // read bus
  output mem_req_t      mem_req_o,
  input  wire mem_rsp_t mem_rsp_i
);

  localparam int LINES = 2 ** IDX_W;
  localparam int WORDS = 2 ** OFF_W;
  // byte offset is always two bits
  localparam int TAG_W = 32 - IDX_W - OFF_W - 2;

  // refill sequence
  // idle -> even read -> gap -> odd read -> done -> idle
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD0,
    ST_GAP,
    ST_RD1,
    ST_DONE
  } state_e;

  state_e state_q;

  // line storage
  logic [TAG_W-1:0] tag_mem  [LINES];
  xlen_t            data_mem [LINES][WORDS];
  logic [LINES-1:0] valid_q;

  // address fields of the current fetch pc
  logic [TAG_W-1:0] pc_tag;
  logic [IDX_W-1:0] pc_idx;
  logic [OFF_W-1:0] pc_off;

  // line being refilled, captured when the miss is seen
  logic [TAG_W-1:0] fill_tag_q;
  logic [IDX_W-1:0] fill_idx_q;
  logic [OFF_W-1:0] fill_off;

  // a flush arrived while the refill was running
  logic             flushed_q;

  logic             line_hit;
  logic             miss;
  logic             rsp_take;

  assign pc_tag = fetch_pc_i[31 -: TAG_W];
  assign pc_idx = fetch_pc_i[2 + OFF_W +: IDX_W];
  assign pc_off = fetch_pc_i[2 +: OFF_W];

  // tag compare, one tag per line
  assign line_hit = valid_q[pc_idx] & (tag_mem[pc_idx] == pc_tag);

  // only report a hit when no refill is in flight
  assign hit_o  = (state_q == ST_IDLE) & line_hit;
  assign miss   = (state_q == ST_IDLE) & ~line_hit;
  assign busy_o = (state_q != ST_IDLE);

  // word read is unconditional, hit_o qualifies it
  assign inst_o = data_mem[pc_idx][pc_off];

  // even word first, then the odd one
  assign fill_off = (state_q == ST_RD1) ? OFF_W'(1) : '0;

  // a response only counts while a read is outstanding
  assign rsp_take = mem_rsp_i.valid & ((state_q == ST_RD0) | (state_q == ST_RD1));

  // request stays up with a stable address until the data comes back
  always_comb begin
    mem_req_o.addr  = {fill_tag_q, fill_idx_q, fill_off, 2'b00};
    mem_req_o.valid = (state_q == ST_RD0) | (state_q == ST_RD1);
  end

  // refill FSM and line valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ST_IDLE;
      valid_q   <= '0;
      flushed_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          flushed_q <= 1'b0;
          // read goes out in the next cycle
          if (miss) begin
            state_q         <= ST_RD0;
            // old contents of this line are about to be overwritten
            valid_q[pc_idx] <= 1'b0;
          end
        end
        ST_RD0: begin
          if (mem_rsp_i.valid) begin
            state_q <= ST_GAP;
          end
        end
        // drop valid for one cycle between the two reads
        ST_GAP: begin
          state_q <= ST_RD1;
        end
        ST_RD1: begin
          if (mem_rsp_i.valid) begin
            state_q <= ST_DONE;
          end
        end
        ST_DONE: begin
          state_q <= ST_IDLE;
          // line becomes usable one cycle after the odd word
          if (!flushed_q) begin
            valid_q[fill_idx_q] <= 1'b1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase

      // invalidate all, wins over the done write above
      if (flush_all_i) begin
        valid_q <= '0;
        if (state_q != ST_IDLE) begin
          flushed_q <= 1'b1;
        end
      end
    end
  end

  // refill address capture and line writes
  always_ff @(posedge clk) begin
    // follow the pc while idle, frozen once the refill starts
    if (state_q == ST_IDLE) begin
      fill_tag_q <= pc_tag;
      fill_idx_q <= pc_idx;
    end
    if (rsp_take) begin
      data_mem[fill_idx_q][fill_off] <= mem_rsp_i.data;
    end
    // tag goes in with the first word
    if (rsp_take && (state_q == ST_RD0)) begin
      tag_mem[fill_idx_q] <= fill_tag_q;
    end
  end

endmodule

`default_nettype wire

//--- logic/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl
  import ifu_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  // cache lookup
  output xlen_t         fetch_pc_o,
  output logic          flush_all_o,
  input  wire logic     hit_i,
  input  wire xlen_t    inst_i,
  input  wire logic     cache_busy_i,
  // to decode
  output fetch_rsp_t    rsp_o,
  output logic          rsp_valid_o,
  input  wire logic     rsp_ready_i,
  // from the backend
  input  wire resolve_t res_i
);

  // fetch pc and the spec flag of the word it points at
  xlen_t pc_q;
  logic  pc_spec_q;

  // waiting for the backend on a load, fence.i or unpredicted branch
  logic  hazard_q;

  // one-entry target buffer, last redirect target
  xlen_t btb_q;
  logic  btb_valid_q;

  // outstanding prediction and the target it assumed
  logic  spec_q;
  xlen_t spec_tgt_q;

  // mispredict seen, restart pending
  logic  bad_q;
  xlen_t bad_tgt_q;

  // predecode of the presented word
  logic [6:0] opcode;
  logic       is_ctrl;
  logic       is_load;
  logic       is_store;
  logic       is_fence;

  // resolution decode
  logic  res_any;
  xlen_t res_next;
  logic  spec_bad;
  logic  spec_d;

  // handshake and per-transfer decisions
  logic  hold_mem;
  logic  fire;
  logic  predict;
  logic  stall;
  logic  release_stall;
  logic  restart;

  assign opcode   = inst_i[6:0];
  assign is_ctrl  = (opcode == OP_JAL) | (opcode == OP_JALR) |
                    (opcode == OP_BRANCH) | (opcode == OP_SYSTEM);
  assign is_load  = (opcode == OP_LOAD);
  assign is_store = (opcode == OP_STORE);
  assign is_fence = (inst_i == INST_FENCE_I);

  // address the core really goes to after the resolved instruction
  assign res_any  = res_i.change | res_i.retire;
  assign res_next = res_i.change ? res_i.npc : res_i.pc + 32'd4;

  // mismatch against the predicted target
  assign spec_bad  = spec_q & res_any & (res_next != spec_tgt_q);

  // memory ops wait until the prediction is confirmed
  assign hold_mem = spec_q & (is_load | is_store);

  // valid drops in the very cycle a mismatch comes in
  assign rsp_valid_o = hit_i & ~hazard_q & ~bad_q & ~spec_bad & ~hold_mem;
  assign fire        = rsp_valid_o & rsp_ready_i;

  // predict only from a filled buffer with nothing outstanding
  assign predict = fire & is_ctrl & btb_valid_q & ~spec_q;
  assign stall   = fire & (is_load | is_fence | (is_ctrl & ~predict));

  // a pulse while speculating belongs to the predicted branch
  assign release_stall = hazard_q & ~spec_q & ~bad_q & res_any;

  // let the running refill finish before moving the pc
  assign restart = bad_q & ~cache_busy_i;

  // next value of the speculation flag
  // set by a prediction, cleared by any resolution pulse
  assign spec_d = predict | (spec_q & ~res_any);

  // whole cache goes on a fence.i transfer
  assign flush_all_o = fire & is_fence;

  assign fetch_pc_o = pc_q;

  // payload only changes with pc_q or pc_spec_q, so it holds under back-pressure
  always_comb begin
    rsp_o.pc   = pc_q;
    rsp_o.inst = inst_i;
    rsp_o.spec = pc_spec_q;
  end

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= PC_RESET;
      pc_spec_q   <= 1'b0;
      hazard_q    <= 1'b0;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      bad_q       <= 1'b0;
    end else begin
      // flag clears one cycle after the resolution pulse
      spec_q <= spec_d;

      if (res_i.change) begin
        btb_valid_q <= 1'b1;
      end

      if (spec_bad) begin
        bad_q <= 1'b1;
      end

      if (restart) begin
        // back on the true path, drop everything fetched since
        bad_q     <= 1'b0;
        hazard_q  <= 1'b0;
        pc_q      <= bad_tgt_q;
        pc_spec_q <= 1'b0;
      end else if (release_stall) begin
        hazard_q <= 1'b0;
        // branch goes to npc, load and fence.i fall through
        if (res_i.change) begin
          pc_q <= res_i.npc;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end else if (fire) begin
        // next word inherits whatever spec will be after this edge
        pc_spec_q <= spec_d;
        if (predict) begin
          pc_q <= btb_q;
        end else if (stall) begin
          // pc stays on the stalling word until resolved
          hazard_q <= 1'b1;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end
    end
  end

  // target buffer and saved targets
  always_ff @(posedge clk) begin
    // refreshed on every redirect
    if (res_i.change) begin
      btb_q <= res_i.npc;
    end
    if (predict) begin
      spec_tgt_q <= btb_q;
    end
    if (spec_bad) begin
      bad_tgt_q <= res_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top
  import ifu_pkg::*;
#(
  // cache geometry, lines and words per line as powers of two
  parameter int IDX_W = 2,
  parameter int OFF_W = 1
) (
  input  wire logic     clk,
  input  wire logic     rst,
  // instruction read bus
  output mem_req_t      mem_req_o,
  input  wire mem_rsp_t mem_rsp_i,
  // to decode
  output fetch_rsp_t    rsp_o,
  output logic          rsp_valid_o,
  input  wire logic     rsp_ready_i,
  // from the backend
  input  wire resolve_t res_i
);

  // controller to cache
  xlen_t fetch_pc;
  logic  flush_all;

  // cache to controller
  logic  hit;
  xlen_t inst;
  logic  cache_busy;

  // pc, predecode and speculation
  fetch_ctrl u_fetch_ctrl (
    .clk          (clk),
    .rst          (rst),
    .fetch_pc_o   (fetch_pc),
    .flush_all_o  (flush_all),
    .hit_i        (hit),
    .inst_i       (inst),
    .cache_busy_i (cache_busy),
    .rsp_o        (rsp_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .res_i        (res_i)
  );

  // direct-mapped l1 instruction cache
  l1i_cache #(
    .IDX_W (IDX_W),
    .OFF_W (OFF_W)
  ) u_l1i_cache (
    .clk         (clk),
    .rst         (rst),
    .fetch_pc_i  (fetch_pc),
    .flush_all_i (flush_all),
    .hit_o       (hit),
    .inst_o      (inst),
    .busy_o      (cache_busy),
    .mem_req_o   (mem_req_o),
    .mem_rsp_i   (mem_rsp_i)
  );

endmodule

`default_nettype wire

//--- verification/tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem
  import ifu_pkg::*;
#(
  parameter int DEPTH_W = 8
) (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire mem_req_t                mem_req_i,
  output mem_rsp_t                     mem_rsp_o,
  // replace the marked words with fresh ones
  input  wire logic                    rewrite_i,
  input  wire logic [2**DEPTH_W-1:0]   rewrite_mask_i
);

  // word array, aliased over the address space by the low bits
  xlen_t       mem [2**DEPTH_W];
  logic [15:0] lfsr_q;
  logic        busy_q;
  int          wait_q;

  // fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic        fb;
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // instruction mix, mostly plain words
  task automatic new_word(output xlen_t w);
    logic [31:0] kind;
    logic [31:0] body;
    kind = rand_bits(4);
    body = rand_bits(25);
    case (kind[3:0])
      4'd0:       w = INST_FENCE_I;
      4'd1, 4'd2: w = {body[24:0], OP_LOAD};
      4'd3, 4'd4: w = {body[24:0], OP_STORE};
      4'd5, 4'd6: w = {body[24:0], OP_BRANCH};
      4'd7:       w = {body[24:0], OP_JAL};
      // op-imm
      default:    w = {body[24:0], 7'b0010011};
    endcase
  endtask

  initial begin
    xlen_t w;
    lfsr_q    = 16'd47;
    busy_q    = 1'b0;
    wait_q    = 0;
    mem_rsp_o = '0;
    for (int i = 0; i < 2**DEPTH_W; i++) begin
      new_word(w);
      mem[i] = w;
    end
  end

  // one read at a time, answered on a later falling edge
  always @(negedge clk) begin
    logic [31:0] r;
    mem_rsp_o.valid = 1'b0;
    if (rst) begin
      busy_q = 1'b0;
    end else if (busy_q) begin
      if (wait_q == 0) begin
        mem_rsp_o.data  = mem[mem_req_i.addr[DEPTH_W+1:2]];
        mem_rsp_o.valid = 1'b1;
        busy_q          = 1'b0;
      end else begin
        wait_q = wait_q - 1;
      end
    end else if (mem_req_i.valid) begin
      busy_q = 1'b1;
      r      = rand_bits(2);
      wait_q = int'(r[1:0]);
    end
  end

  // self-modifying code after a fence.i
  always @(posedge clk) begin
    xlen_t w;
    if (rewrite_i) begin
      for (int i = 0; i < 2**DEPTH_W; i++) begin
        if (rewrite_mask_i[i]) begin
          new_word(w);
          mem[i] = w;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/ifu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_tb
  import ifu_pkg::*;
;

  localparam int DEPTH_W    = 8;
  localparam int N_ACCEPT   = 2000;
  localparam int IDLE_LIMIT = 500;

  logic       clk;
  logic       rst;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  fetch_rsp_t rsp;
  logic       rsp_valid;
  logic       rsp_ready;
  resolve_t   res;
  logic       rewrite;
  logic [2**DEPTH_W-1:0] rewrite_mask;

  // model state
  logic [15:0] lfsr_q;
  xlen_t exp_pc;
  logic  exp_spec;
  logic  in_spec;
  xlen_t pred_tgt;
  xlen_t spec_true;
  xlen_t br_pc;
  int    spec_wait;
  logic  haz;
  logic  haz_ctrl;
  xlen_t haz_pc;
  xlen_t haz_tgt;
  int    haz_wait;
  logic  btb_v;
  xlen_t btb;
  logic  rewrite_pend;
  logic [2**DEPTH_W-1:0] fetched;
  logic  prev_stall;
  fetch_rsp_t prev_rsp;
  // read request still waiting for its data
  logic  req_hold;
  mem_req_t prev_req;
  int    accepted;
  int    idle_cycles;

  ifu_top #(
    .IDX_W (2),
    .OFF_W (1)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .res_i       (res)
  );

  tb_mem #(
    .DEPTH_W (DEPTH_W)
  ) u_mem (
    .clk            (clk),
    .rst            (rst),
    .mem_req_i      (mem_req),
    .mem_rsp_o      (mem_rsp),
    .rewrite_i      (rewrite),
    .rewrite_mask_i (rewrite_mask)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic        fb;
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // word aligned, inside the memory window
  task automatic random_target(output xlen_t t);
    logic [31:0] r;
    r = rand_bits(8);
    t = PC_RESET + {22'd0, r[7:0], 2'b00};
  endtask

  function automatic logic is_ctrl_op(input xlen_t w);
    return (w[6:0] == OP_JAL) || (w[6:0] == OP_JALR) ||
           (w[6:0] == OP_BRANCH) || (w[6:0] == OP_SYSTEM);
  endfunction

  function automatic logic is_mem_op(input xlen_t w);
    return (w[6:0] == OP_LOAD) || (w[6:0] == OP_STORE);
  endfunction

  // waits for retire
  function automatic logic is_retire_op(input xlen_t w);
    return (w[6:0] == OP_LOAD) || (w == INST_FENCE_I);
  endfunction

  task automatic flag_mismatch(input string name, input xlen_t got, input xlen_t exp);
    $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("%0t ns: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  initial begin
    logic [31:0] r;
    logic accept;
    logic spec_pulse;
    logic haz_pulse;
    logic spec_next;
    logic [DEPTH_W-1:0] idx;
    rst          = 1'b1;
    rsp_ready    = 1'b0;
    res          = '0;
    rewrite      = 1'b0;
    rewrite_mask = '0;
    lfsr_q       = 16'd47;
    exp_pc       = PC_RESET;
    exp_spec     = 1'b0;
    in_spec      = 1'b0;
    haz          = 1'b0;
    btb_v        = 1'b0;
    rewrite_pend = 1'b0;
    fetched      = '0;
    prev_stall   = 1'b0;
    req_hold     = 1'b0;
    accepted     = 0;
    idle_cycles  = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    while (accepted < N_ACCEPT) begin
      @(negedge clk);
      res        = '0;
      spec_pulse = 1'b0;
      haz_pulse  = 1'b0;
      // old words replaced right after the fence.i flush
      rewrite = rewrite_pend;
      if (rewrite_pend) begin
        rewrite_mask = fetched;
        fetched      = '0;
        rewrite_pend = 1'b0;
      end
      r         = rand_bits(2);
      rsp_ready = |r[1:0];

      // backend, the prediction resolves before any later hazard
      if (in_spec) begin
        if (spec_wait > 0) begin
          spec_wait--;
        end else begin
          res.change = 1'b1;
          res.npc    = spec_true;
          res.pc     = br_pc;
          spec_pulse = 1'b1;
        end
      end else if (haz) begin
        if (haz_wait > 0) begin
          haz_wait--;
        end else begin
          res.change = haz_ctrl;
          res.retire = ~haz_ctrl;
          res.npc    = haz_tgt;
          res.pc     = haz_pc;
          haz_pulse  = 1'b1;
        end
      end
      #1;

      // read request held with its address until the data comes back
      if (req_hold) begin
        assert (mem_req.valid) else
          abort_run("read request dropped before its response arrived");
        assert (mem_req.addr == prev_req.addr) else
          flag_mismatch("mem_req_o.addr", mem_req.addr, prev_req.addr);
      end
      req_hold = mem_req.valid & ~mem_rsp.valid;
      prev_req = mem_req;

      accept = rsp_valid & rsp_ready;
      if (prev_stall && rsp_valid) begin
        assert (rsp == prev_rsp) else
          abort_run("rsp_o changed while valid was high and ready low");
      end
      prev_stall = rsp_valid & ~rsp_ready;
      prev_rsp   = rsp;
      if (spec_pulse && (spec_true != pred_tgt)) begin
        assert (!accept) else
          abort_run("response accepted in the cycle of a mispredicted resolution");
      end

      if (accept) begin
        idx = rsp.pc[DEPTH_W+1:2];
        assert (!haz) else
          abort_run("response accepted while fetch was stalled on the backend");
        assert (rsp.pc == exp_pc) else flag_mismatch("rsp_o.pc", rsp.pc, exp_pc);
        assert (rsp.inst == u_mem.mem[idx]) else
          flag_mismatch("rsp_o.inst", rsp.inst, u_mem.mem[idx]);
        assert (rsp.spec == exp_spec) else
          flag_mismatch("rsp_o.spec", 32'(rsp.spec), 32'(exp_spec));
        assert (!(in_spec && is_mem_op(rsp.inst))) else
          abort_run("load or store accepted while a prediction was outstanding");
        fetched[idx] = 1'b1;
        accepted++;
        spec_next = in_spec & ~spec_pulse;
        if (is_ctrl_op(rsp.inst) && btb_v && !in_spec) begin
          // predicted from the target buffer, half of them right
          spec_next = 1'b1;
          pred_tgt  = btb;
          br_pc     = rsp.pc;
          exp_pc    = btb;
          r         = rand_bits(1);
          if (r[0]) begin
            spec_true = btb;
          end else begin
            random_target(spec_true);
          end
          r         = rand_bits(3);
          spec_wait = int'(r[2:0]);
        end else if (is_ctrl_op(rsp.inst) || is_retire_op(rsp.inst)) begin
          haz      = 1'b1;
          haz_ctrl = is_ctrl_op(rsp.inst);
          haz_pc   = rsp.pc;
          random_target(haz_tgt);
          r        = rand_bits(2);
          haz_wait = int'(r[1:0]);
          if (rsp.inst == INST_FENCE_I) begin
            rewrite_pend = 1'b1;
          end
        end else begin
          exp_pc = rsp.pc + 32'd4;
        end
        // next word carries the speculation state after this edge
        exp_spec = spec_next;
        in_spec  = spec_next;
        idle_cycles = 0;
      end else begin
        idle_cycles++;
      end

      if (spec_pulse) begin
        in_spec = 1'b0;
        btb     = spec_true;
        btb_v   = 1'b1;
        // wrong path dropped, hazards on it too
        if (spec_true != pred_tgt) begin
          exp_pc   = spec_true;
          exp_spec = 1'b0;
          haz      = 1'b0;
        end
      end
      if (haz_pulse) begin
        haz = 1'b0;
        if (haz_ctrl) begin
          exp_pc = haz_tgt;
          btb    = haz_tgt;
          btb_v  = 1'b1;
        end else begin
          exp_pc = haz_pc + 32'd4;
        end
      end

      assert (idle_cycles < IDLE_LIMIT) else
        abort_run("timeout, no instruction accepted for too many cycles");
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
logic/ifu_pkg.sv
logic/l1i_cache.sv
logic/fetch_ctrl.sv
logic/ifu_top.sv
verification/tb_mem.sv
verification/ifu_tb.sv
